// ==== verilog/arb_pkg.sv ====
//############################
// AHB encodings and arbiter types, imported by the RTL and the testbench
//############################
package arb_pkg;

   typedef enum logic [1:0] {
      trans_idle   = 2'b00,
      trans_busy   = 2'b01,
      trans_nonseq = 2'b10,
      trans_seq    = 2'b11
   } htrans_e;

   typedef enum logic [2:0] {
      size_byte = 3'b000,
      size_half = 3'b001,
      size_word = 3'b010
   } hsize_e;

   typedef enum logic [2:0] {
      burst_single, burst_incr, burst_wrap4, burst_incr4,
      burst_wrap8, burst_incr8, burst_wrap16, burst_incr16
   } hburst_e;

   // Master 2 control for the current transfer
   typedef struct packed {
      htrans_e htrans;
      hsize_e  hsize;
      hburst_e hburst;
   } ahb_ctrl_t;

   typedef struct packed {
      logic preempt;   // Take the bus away on the matching grant
      logic hold;      // Delay the matching grant
   } fault_flags_t;

   typedef enum logic [2:0] {
      st_idle, st_m1_grant, st_m1_own, st_m2_wait, st_m2_own, st_m2_burst, st_m2_done
   } arb_state_e;

   typedef enum logic [3:0] {
      hm_none    = 4'd0,
      hm_master1 = 4'd1,
      hm_master2 = 4'd2
   } hmaster_e;

endpackage

// ==== verilog/grant_delay.sv ====
//############################
// Master 2 grant counter with hold-off and preempt timers
//############################
`timescale 1ns/1ps

module grant_delay
#(
   parameter int DELAY_W    = 16,
   parameter int TRANS_NO_W = 8
)
(
   input  logic                  hclk,
   input  logic                  hresetn,
   input  logic                  m2_req_pulse,    // Entering m2_wait
   input  logic                  m2_start_pulse,  // Entering m2_own
   input  logic [DELAY_W-1:0]    delay_val,
   input  logic [TRANS_NO_W-1:0] trans_no,
   input  arb_pkg::fault_flags_t flags,
   output logic                  hold_busy,
   output logic                  preempt_busy
);

   logic [TRANS_NO_W-1:0] grant_cnt;
   logic [TRANS_NO_W-1:0] grant_cnt_nxt;
   logic [DELAY_W-1:0]    hold_cnt;
   logic [DELAY_W-1:0]    preempt_cnt;
   logic                  hold_hit;
   logic                  preempt_hit;

   assign grant_cnt_nxt = grant_cnt + TRANS_NO_W'(1);

   // Hold matches the new count, preempt the count already taken
   assign hold_hit    = m2_req_pulse && flags.hold && (grant_cnt_nxt == trans_no);
   assign preempt_hit = m2_start_pulse && flags.preempt && (grant_cnt == trans_no);

   always_ff @(posedge hclk or negedge hresetn)
   begin
      if (!hresetn)
         grant_cnt <= '0;
      else if (m2_req_pulse)
         grant_cnt <= grant_cnt_nxt;
   end

   always_ff @(posedge hclk or negedge hresetn)
   begin
      if (!hresetn)
         hold_cnt <= '0;
      else if (hold_hit)
         hold_cnt <= delay_val;
      else if (hold_busy)
         hold_cnt <= hold_cnt - DELAY_W'(1);
   end

   always_ff @(posedge hclk or negedge hresetn)
   begin
      if (!hresetn)
         preempt_cnt <= '0;
      else if (preempt_hit)
         preempt_cnt <= delay_val;
      else if (preempt_busy)
         preempt_cnt <= preempt_cnt - DELAY_W'(1);
   end

   assign hold_busy    = |hold_cnt;
   assign preempt_busy = |preempt_cnt;   // Zero delay_val never preempts

endmodule

// ==== verilog/burst_tracker.sv ====
//############################
// Tracks master 2 bursts and flags the last beat address
//############################
`timescale 1ns/1ps

module burst_tracker
(
   input  logic               hclk,
   input  logic               hresetn,
   input  logic               hready,
   input  logic               hgrant2,      // Capture enable
   input  logic [31:0]        haddr,
   input  arb_pkg::ahb_ctrl_t ctrl,
   output logic               burst_active,
   output logic               burst_last,
   output logic               xfer_idle
);
   import arb_pkg::*;

   logic [31:0] start_addr;
   htrans_e     htrans_q;
   hsize_e      hsize_q;
   logic [3:0]  last_beat;                   // Beats minus one
   logic [1:0]  size_shift;
   logic [31:0] last_addr;

   // First address of the burst
   always_ff @(posedge hclk)
   begin
      if (ctrl.htrans == trans_nonseq)
         start_addr <= haddr;
   end

   always_ff @(posedge hclk or negedge hresetn)
   begin
      if (!hresetn)
      begin
         htrans_q <= trans_idle;
         hsize_q  <= size_byte;
      end
      else if (hready && hgrant2)
      begin
         htrans_q <= ctrl.htrans;
         hsize_q  <= ctrl.hsize;
      end
   end

   always_comb
   begin
      case (ctrl.hburst)
         burst_incr4:  last_beat = 4'd3;
         burst_incr8:  last_beat = 4'd7;
         burst_incr16: last_beat = 4'd15;
         default:      last_beat = 4'd0;     // Not a tracked burst
      endcase
   end

   assign size_shift = (hsize_q == size_word) ? 2'd2 : ((hsize_q == size_half) ? 2'd1 : 2'd0);
   assign last_addr  = start_addr + ({28'd0, last_beat} << size_shift);

   assign burst_active = (last_beat != 4'd0) &&
                         (htrans_q == trans_nonseq || htrans_q == trans_seq) &&
                         (hsize_q == size_half || hsize_q == size_word);
   assign burst_last   = (haddr == last_addr);
   assign xfer_idle    = (htrans_q == trans_idle);

endmodule

// ==== verilog/grant_fsm.sv ====
//############################
// Arbitration FSM with grant decode and hmaster register
//############################
`timescale 1ns/1ps

module grant_fsm
(
   input  logic       hclk,
   input  logic       hresetn,
   input  logic       hbusreq1,
   input  logic       hbusreq2,
   input  logic       hready,
   input  logic       hold_busy,       // Hold-off still running
   input  logic       preempt_busy,    // Master 2 locked out
   input  logic       burst_active,
   input  logic       burst_last,
   input  logic       xfer_idle,
   output logic       hgrant1,
   output logic       hgrant2,
   output logic       m2_req_pulse,
   output logic       m2_start_pulse,
   output logic [3:0] hmaster
);
   import arb_pkg::*;

   arb_state_e state;
   arb_state_e next_state;
   hmaster_e   hmaster_q;

   always_ff @(posedge hclk or negedge hresetn)
   begin
      if (!hresetn)
         state <= st_idle;
      else
         state <= next_state;
   end

   always_comb
   begin
      next_state = state;
      case (state)
         st_idle:
         begin
            if (hbusreq2 && !preempt_busy)
               next_state = st_m2_wait;            // Core master first
            else if (hbusreq1)
               next_state = st_m1_grant;
         end
         st_m1_grant:
            next_state = st_m1_own;
         st_m1_own:
         begin
            // Master 2 request takes the bus back from master 1
            if (hbusreq2 && !preempt_busy)
               next_state = st_m2_wait;
            else if (!hbusreq1)
               next_state = st_idle;
         end
         st_m2_wait:
         begin
            if (!hold_busy)
               next_state = st_m2_own;
         end
         st_m2_own:
         begin
            if (preempt_busy)
               next_state = st_idle;               // Preempted
            else if (!hbusreq2)
            begin
               if (burst_active)
                  next_state = st_m2_burst;
               else if (xfer_idle)
                  next_state = st_idle;
            end
         end
         st_m2_burst:
         begin
            if (burst_last)
               next_state = st_m2_done;
         end
         st_m2_done:
            next_state = st_idle;                  // One ungranted cycle
         default:
            next_state = st_idle;
      endcase
   end

   assign hgrant1 = (state == st_m1_grant) || (state == st_m1_own);
   assign hgrant2 = (state == st_m2_own) || (state == st_m2_burst);

   // Pulses fire in the cycle whose edge enters the state
   assign m2_req_pulse   = (next_state == st_m2_wait) && (state != st_m2_wait);
   assign m2_start_pulse = (next_state == st_m2_own) && (state == st_m2_wait);

   always_ff @(posedge hclk or negedge hresetn)
   begin
      if (!hresetn)
         hmaster_q <= hm_none;
      else if (hready)                             // Frozen during wait states
      begin
         if (hgrant1)
            hmaster_q <= hm_master1;
         else if (hgrant2)
            hmaster_q <= hm_master2;
         else
            hmaster_q <= hm_none;
      end
   end

   assign hmaster = hmaster_q;

endmodule

// ==== verilog/ahb_arbiter.sv ====
//############################
// Two-master AHB arbiter top, master 2 has priority
// Drop in place of the fabric arbiter
//############################
`timescale 1ns/1ps

module ahb_arbiter
#(
   parameter int DELAY_W    = 16,
   parameter int TRANS_NO_W = 8
)
(
   input  logic                    hclk,
   input  logic                    hresetn,
   input  logic                    hbusreq1,
   input  logic                    hbusreq2,
   input  logic [31:0]             haddr,
   input  logic                    hready,
   input  arb_pkg::ahb_ctrl_t      ctrl,        // Master 2 htrans, hsize, hburst
   input  logic [DELAY_W-1:0]      delay_val,
   input  logic [TRANS_NO_W-1:0]   trans_no,
   input  arb_pkg::fault_flags_t   flags,
   output logic                    hgrant1,
   output logic                    hgrant2,
   output logic [3:0]              hmaster
);

   logic m2_req_pulse;
   logic m2_start_pulse;
   logic hold_busy;
   logic preempt_busy;
   logic burst_active;
   logic burst_last;
   logic xfer_idle;

   grant_fsm u_grant_fsm
   (
      .hclk           (hclk),
      .hresetn        (hresetn),
      .hbusreq1       (hbusreq1),
      .hbusreq2       (hbusreq2),
      .hready         (hready),
      .hold_busy      (hold_busy),
      .preempt_busy   (preempt_busy),
      .burst_active   (burst_active),
      .burst_last     (burst_last),
      .xfer_idle      (xfer_idle),
      .hgrant1        (hgrant1),
      .hgrant2        (hgrant2),
      .m2_req_pulse   (m2_req_pulse),
      .m2_start_pulse (m2_start_pulse),
      .hmaster        (hmaster)
   );

   // Watches master 2's burst while it owns the bus
   burst_tracker u_burst_tracker
   (
      .hclk         (hclk),
      .hresetn      (hresetn),
      .hready       (hready),
      .hgrant2      (hgrant2),
      .haddr        (haddr),
      .ctrl         (ctrl),
      .burst_active (burst_active),
      .burst_last   (burst_last),
      .xfer_idle    (xfer_idle)
   );

   grant_delay
   #(
      .DELAY_W    (DELAY_W),
      .TRANS_NO_W (TRANS_NO_W)
   )
   u_grant_delay
   (
      .hclk           (hclk),
      .hresetn        (hresetn),
      .m2_req_pulse   (m2_req_pulse),
      .m2_start_pulse (m2_start_pulse),
      .delay_val      (delay_val),
      .trans_no       (trans_no),
      .flags          (flags),
      .hold_busy      (hold_busy),
      .preempt_busy   (preempt_busy)
   );

endmodule

// ==== testbench/tb_arbiter.sv ====
//############################
// Self-checking testbench for the AHB arbiter
// Replays the scenarios listed in the testdata file
//############################
`timescale 1ns/1ps

module tb_arbiter;
   import arb_pkg::*;

   logic         hclk;
   logic         hresetn;
   logic         hbusreq1;
   logic         hbusreq2;
   logic [31:0]  haddr;
   logic         hready;
   ahb_ctrl_t    ctrl;
   logic [15:0]  delay_val;
   logic [7:0]   trans_no;
   fault_flags_t flags;
   logic         hgrant1;
   logic         hgrant2;
   logic [3:0]   hmaster;

   logic [31:0]  rng = 32'h1886_ea73;
   int           err_cnt = 0;
   int           m2_count = 0;           // Master 2 grants taken so far
   hmaster_e     exp_hm = hm_none;

   ahb_arbiter #(.DELAY_W(16), .TRANS_NO_W(8)) dut (.*);

   initial
   begin
      hclk = 1'b0;
      forever #5 hclk = ~hclk;
   end

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      return y ^ (y << 5);
   endfunction

   // Grant exclusion and the hmaster register model
   always @(negedge hclk)
   begin
      if (hresetn)
      begin
         assert (!(hgrant1 && hgrant2))
         else
         begin
            $display("FAILED at %0t: hgrant2 expected 0 got 1 while hgrant1 high", $time);
            err_cnt++;
         end
         assert (hmaster == exp_hm)
         else
         begin
            $display("FAILED at %0t: hmaster expected %0d got %0d", $time, exp_hm, hmaster);
            err_cnt++;
         end
         if (hready)
            exp_hm = hgrant1 ? hm_master1 : (hgrant2 ? hm_master2 : hm_none);
      end
   end

   task automatic check_range(input string name, input int got, input int lo, input int hi);
      if (got >= 0)                         // Negative means a timeout already reported
      begin
         assert (got >= lo && got <= hi)
         else
         begin
            if (lo == hi)
               $display("FAILED at %0t: %s expected %0d got %0d", $time, name, lo, got);
            else
               $display("FAILED at %0t: %s expected %0d to %0d got %0d",
                        $time, name, lo, hi, got);
            err_cnt++;
         end
      end
   endtask

   // Counts clock edges until a grant reaches the level
   task automatic wait_grant(input int which, input logic level, input int limit,
                             output int cycles, output logic other_seen);
      logic hit;
      cycles = 0;
      other_seen = 1'b0;
      hit = 1'b0;
      while (!hit && cycles <= limit)
      begin
         @(negedge hclk);
         hit = (((which == 1) ? hgrant1 : hgrant2) == level);
         if (!hit)
         begin
            other_seen |= (which == 1) ? hgrant2 : hgrant1;
            cycles++;
         end
      end
      if (!hit)
      begin
         $display("TIMEOUT at %0t: hgrant%0d did not reach %0b within %0d cycles",
                  $time, which, level, limit);
         err_cnt++;
         cycles = -1;
      end
   endtask

   // A matching hold-off stretches the grant by delay_val
   task automatic check_m2_latency(input int n, input logic held, input int delay);
      if (held)
         check_range("hgrant2 held latency", n, delay + 1, delay + 4);
      else
         check_range("hgrant2 latency", n, 2, 2);
   endtask

   task automatic drive_req(input logic r1, input logic r2);
      @(posedge hclk);
      hbusreq1 <= r1;
      hbusreq2 <= r2;
   endtask

   initial
   begin
      int          fd;
      string       line;
      int          req, burst, size, hold, preempt, delay, tno, outcome;
      int          n, scen, err_before, beats, bytes;
      logic [31:0] addr;
      logic        other;
      logic        hold_hit;
      hresetn   = 1'b0;
      hbusreq1  = 1'b0;
      hbusreq2  = 1'b0;
      haddr     = '0;
      hready    = 1'b1;
      ctrl      = '{htrans: trans_idle, hsize: size_word, hburst: burst_single};
      delay_val = '0;
      trans_no  = '0;
      flags     = '0;
      scen      = 0;
      repeat (4) @(posedge hclk);
      hresetn <= 1'b1;
      @(negedge hclk);
      check_range("hgrant1 after reset", int'(hgrant1), 0, 0);
      check_range("hgrant2 after reset", int'(hgrant2), 0, 0);
      fd = $fopen("testbench/arbiter_testdata.txt", "r");
      if (fd == 0)
      begin
         $display("Could not open the test data file");
         err_cnt++;
      end
      while (fd != 0 && !$feof(fd))
      begin
         line = "";
         void'($fgets(line, fd));
         if ($sscanf(line, "%d %d %d %h %d %d %d %d %d", req, burst, size, addr,
                     hold, preempt, delay, tno, outcome) != 9)
            continue;                       // Comment or blank line
         scen++;
         err_before = err_cnt;
         hold_hit = (hold != 0) && (tno == m2_count + 1);
         @(posedge hclk);
         flags     <= '{preempt: preempt[0], hold: hold[0]};
         delay_val <= 16'(delay);
         trans_no  <= 8'(tno);
         hbusreq1  <= req[0];
         hbusreq2  <= req[1];
         case (outcome)
            0:
            begin
               wait_grant(1, 1'b1, 3, n, other);
               check_range("hgrant1 latency", n, 1, 3);
               @(posedge hclk);
               hready   <= 1'b0;            // hmaster must hold through the release
               hbusreq1 <= 1'b0;
               wait_grant(1, 1'b0, 4, n, other);
               repeat (2) @(posedge hclk);
               hready <= 1'b1;
            end
            1:
            begin
               wait_grant(2, 1'b1, delay + 8, n, other);
               check_m2_latency(n, hold_hit, delay);
               m2_count++;
               drive_req(1'b0, 1'b0);
               wait_grant(2, 1'b0, 4, n, other);
            end
            2:
            begin
               wait_grant(2, 1'b1, delay + 8, n, other);
               check_m2_latency(n, hold_hit, delay);
               m2_count++;
               beats = (burst == 3) ? 4 : ((burst == 5) ? 8 : 16);
               bytes = 1 << size;
               for (int i = 0; i < beats; i++)
               begin
                  @(posedge hclk);
                  haddr    <= addr + 32'(i * bytes);
                  ctrl     <= '{htrans: (i == 0) ? trans_nonseq : trans_seq,
                                hsize: hsize_e'(size), hburst: hburst_e'(burst)};
                  hbusreq2 <= (i == 0);     // Request dropped after NONSEQ
                  @(negedge hclk);
                  check_range("hgrant2 before last beat", int'(hgrant2), 1, 1);
               end
               @(posedge hclk);
               ctrl <= '{htrans: trans_idle, hsize: size_word, hburst: burst_single};
               wait_grant(2, 1'b0, 3, n, other);
               check_range("hgrant2 release after last beat", n, 0, 0);
            end
            3:
            begin
               if (preempt == 0 || tno != m2_count + 1 || delay == 0)
               begin
                  $display("Scenario %0d does not select a preemption", scen);
                  err_cnt++;
               end
               wait_grant(2, 1'b1, 8, n, other);
               check_m2_latency(n, hold_hit, delay);
               wait_grant(2, 1'b0, 3, n, other);
               wait_grant(2, 1'b1, delay + 10, n, other);
               // The drop wait already saw the first low cycle
               check_range("hgrant2 lockout cycles", (n < 0) ? n : n + 1, delay, delay + 3);
               if (req[0])
                  check_range("hgrant1 during lockout", int'(other), 1, 1);
               m2_count += 2;               // Preempted grant plus the regrant
               drive_req(1'b0, 1'b0);
               wait_grant(2, 1'b0, 4, n, other);
            end
            default:
            begin
               wait_grant(2, 1'b1, delay + 8, n, other);
               check_m2_latency(n, hold_hit, delay);
               check_range("hgrant1 before hgrant2", int'(other), 0, 0);
               m2_count++;
               drive_req(1'b1, 1'b0);
               wait_grant(1, 1'b1, 6, n, other);
               drive_req(1'b0, 1'b0);
               wait_grant(1, 1'b0, 4, n, other);
            end
         endcase
         @(posedge hclk);
         flags    <= '0;
         hbusreq1 <= 1'b0;
         hbusreq2 <= 1'b0;
         rng = xorshift(rng);
         repeat (rng % 4) @(posedge hclk);  // Random idle gap
         $display("Scenario %0d code %0d: %s", scen, outcome,
                  (err_cnt == err_before) ? "ok" : "failed");
      end
      if (fd != 0)
         $fclose(fd);
      $display("Scenarios run %0d, errors %0d", scen, err_cnt);
      if (err_cnt == 0 && scen > 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule

// ==== testbench/arbiter_testdata.txt ====
# req(bit0 m1, bit1 m2) hburst hsize addr(hex) hold preempt delay_val trans_no outcome
# outcome 0 m1 alone, 1 m2 single, 2 m2 burst, 3 preemption, 4 both request
1 0 2 00000000 0 0 0 0 0
2 0 2 00000000 0 0 0 0 1
2 0 2 00000000 1 0 6 2 1
2 0 2 00000000 1 0 6 9 1
2 3 1 00001000 0 0 0 0 2
2 3 2 00002000 0 0 0 0 2
2 5 1 00003010 0 0 0 0 2
2 5 2 00004020 0 0 0 0 2
2 7 1 00005000 0 0 0 0 2
2 7 2 0000a000 0 0 0 0 2
3 0 2 00000000 0 0 0 0 4
3 0 2 00000000 0 1 5 11 3
1 0 2 00000000 0 0 0 0 0
2 0 2 00000000 1 0 3 13 1
3 0 2 00000000 0 1 8 14 3
2 3 2 0000fff0 0 0 0 0 2
3 0 2 00000000 0 0 0 0 4

// ==== flist.f ====
verilog/arb_pkg.sv
verilog/grant_delay.sv
verilog/burst_tracker.sv
verilog/grant_fsm.sv
verilog/ahb_arbiter.sv
testbench/tb_arbiter.sv

// ==== Makefile ====
# Verilator build and run of the AHB arbiter testbench

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the Verilator build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing --top-module tb_arbiter -f flist.f
	@out="$$(./obj_dir/Vtb_arbiter)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir
